//--- bench/fcpu_golden.txt
// instruction word, expected CDB value (the stored value for ST)
// the tag of each line is its position, counting from 0
5205 0005
55a3 01a3
0642 01a8
1842 fe62
767e 01a8
6a80 01a8
3d44 ffca
4dbf ffc9
4f9f ffe8
23c3 01a8
7e09 ffe8
5407 0007
6882 ffe8
0041 0350
6620 0000

//--- compile.f
+incdir+verilog
verilog/fcpu_pkg.sv
verilog/issue_queue.sv
verilog/fcpu_decode.sv
verilog/alu_unit.sv
verilog/memory_management_unit.sv
verilog/cdb_arbiter.sv
verilog/fcpu.sv
bench/fcpu_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = fcpu_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the simulation output holds the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/fcpu_tb.sv
`timescale 1ns/1ps
`include "fcpu_macros.svh"

module fcpu_tb import fcpu_pkg::*; ();

   localparam int N_INSTR    = 15;
   localparam int MAX_CYCLES = N_INSTR * 20 + 100;

   logic   clk;
   logic   arst_n;
   logic   instr_valid;
   instr_t instr;
   logic   instr_credit;
   logic   cdb_valid;
   cdb_t   cdb;

   // Instruction words at even entries and expected CDB values at odd ones
   logic [15:0] golden [2*N_INSTR];
   logic        seen [N_INSTR];

   int credits;
   int credit_pulses;
   int sent;
   int results;
   int cycle_count;
   int seed;
   int idle;

   fcpu fcpu_i (
      .clk          (clk),
      .arst_n       (arst_n),
      .instr_valid  (instr_valid),
      .instr        (instr),
      .instr_credit (instr_credit),
      .cdb_valid    (cdb_valid),
      .cdb          (cdb)
   );

   always #5 clk = ~clk;

   task automatic abort_run(input string msg);
      $display("ERROR at %0t ns: %s", $time, msg);
      $display("Test FAILED");
      $fatal(1, "run stopped after the first error");
   endtask

   task automatic report_mismatch(input string name, input logic [15:0] got,
                                  input logic [15:0] exp);
      $display("CHECK FAILED at %0t ns: %s got 0x%04h expected 0x%04h",
               $time, name, got, exp);
      abort_run("value mismatch on the DUT outputs");
   endtask

   // Result looked up by tag with rd and write_en from the instruction word
   task automatic check_result();
      int          idx;
      instr_t      word;
      logic [15:0] exp_value;
      logic        exp_we;
      idx = int'(cdb.tag);
      assert (idx < sent) else abort_run("CDB carries a tag that was never sent");
      assert (!seen[idx]) else abort_run("CDB repeats a tag that already completed");
      word      = instr_t'(golden[2*idx]);
      exp_value = golden[2*idx+1];
      exp_we    = (word.opcode != OP_ST);
      assert (cdb.value == exp_value) else report_mismatch("cdb.value", cdb.value, exp_value);
      assert (cdb.rd == word.rd) else report_mismatch("cdb.rd", 16'(cdb.rd), 16'(word.rd));
      assert (cdb.write_en == exp_we)
         else report_mismatch("cdb.write_en", 16'(cdb.write_en), 16'(exp_we));
      seen[idx] = 1'b1;
      results   = results + 1;
   endtask

   // Credit and CDB monitor on the falling edge
   always @(negedge clk) begin
      if (arst_n) begin
         if (instr_credit) begin
            credits       = credits + 1;
            credit_pulses = credit_pulses + 1;
         end
         if (cdb_valid)
            check_result();
      end
   end

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > MAX_CYCLES)
         abort_run("timeout, not every result came back within the cycle limit");
   end

   initial begin
      clk           = 1'b0;
      arst_n        = 1'b0;
      instr_valid   = 1'b0;
      instr         = '0;
      credits       = `FCPU_INSTR_CREDITS;
      credit_pulses = 0;
      sent          = 0;
      results       = 0;
      cycle_count   = 0;
      seed          = 65927;
      for (int i = 0; i < N_INSTR; i++)
         seen[i] = 1'b0;
      $readmemh("bench/fcpu_golden.txt", golden);

      repeat (5) @(posedge clk);
      #1;
      arst_n = 1'b1;

      // Nothing may come out while no instruction is sent
      repeat (8) begin
         @(negedge clk);
         assert (!cdb_valid) else report_mismatch("cdb_valid", 16'(cdb_valid), 16'h0);
         assert (!instr_credit)
            else report_mismatch("instr_credit", 16'(instr_credit), 16'h0);
      end
      @(posedge clk);
      #1;

      for (int i = 0; i < N_INSTR; i++) begin
         idle = $random(seed) & 3;
         repeat (idle) begin
            @(posedge clk);
            #1;
         end
         while (credits == 0) begin
            @(posedge clk);
            #1;
         end
         instr_valid = 1'b1;
         instr       = instr_t'(golden[2*i]);
         credits     = credits - 1;
         sent        = sent + 1;
         @(posedge clk);
         #1;
         instr_valid = 1'b0;
      end

      while (results < N_INSTR)
         @(posedge clk);

      // A stray or repeated result would show up in this quiet period
      repeat (5) @(posedge clk);

      assert (credits == `FCPU_INSTR_CREDITS)
         else report_mismatch("credits", 16'(credits), 16'(`FCPU_INSTR_CREDITS));
      assert (credit_pulses == sent)
         else report_mismatch("instr_credit pulses", 16'(credit_pulses), 16'(sent));

      $display("Test OK");
      $finish;
   end

endmodule

//--- verilog/fcpu.sv
`timescale 1ns/1ps
`include "fcpu_macros.svh"

module fcpu import fcpu_pkg::*; (
   input  logic   clk,
   input  logic   arst_n,
   input  logic   instr_valid,
   input  instr_t instr,
   output logic   instr_credit,
   output logic   cdb_valid,
   output cdb_t   cdb
);

   // Decode side of the queues
   logic   alu_push;
   issue_t alu_entry;
   logic   alu_credit;
   logic   mem_push;
   issue_t mem_entry;
   logic   mem_credit;

   // Queue heads toward the units
   logic   alu_q_valid;
   issue_t alu_q_entry;
   logic   alu_pop;
   logic   mem_q_valid;
   issue_t mem_q_entry;
   logic   mem_pop;

   // Unit results toward the arbiter
   logic   alu_res_valid;
   cdb_t   alu_res;
   logic   alu_res_ready;
   logic   mem_res_valid;
   cdb_t   mem_res;
   logic   mem_res_ready;

   fcpu_decode decode_i (
      .clk          (clk),
      .arst_n       (arst_n),
      .instr_valid  (instr_valid),
      .instr        (instr),
      .instr_credit (instr_credit),
      .alu_push     (alu_push),
      .alu_entry    (alu_entry),
      .alu_credit   (alu_credit),
      .mem_push     (mem_push),
      .mem_entry    (mem_entry),
      .mem_credit   (mem_credit),
      .cdb_valid    (cdb_valid),
      .cdb          (cdb)
   );

   issue_queue #(
      .entry_t (issue_t),
      .depth   (`FCPU_QDEPTH)
   ) alu_queue_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .push      (alu_push),
      .entry_in  (alu_entry),
      .valid     (alu_q_valid),
      .entry_out (alu_q_entry),
      .pop       (alu_pop),
      .credit    (alu_credit)
   );

   issue_queue #(
      .entry_t (issue_t),
      .depth   (`FCPU_QDEPTH)
   ) mem_queue_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .push      (mem_push),
      .entry_in  (mem_entry),
      .valid     (mem_q_valid),
      .entry_out (mem_q_entry),
      .pop       (mem_pop),
      .credit    (mem_credit)
   );

   alu_unit alu_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .valid     (alu_q_valid),
      .entry     (alu_q_entry),
      .pop       (alu_pop),
      .res_valid (alu_res_valid),
      .res       (alu_res),
      .res_ready (alu_res_ready)
   );

   memory_management_unit mmu_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .valid     (mem_q_valid),
      .entry     (mem_q_entry),
      .pop       (mem_pop),
      .res_valid (mem_res_valid),
      .res       (mem_res),
      .res_ready (mem_res_ready)
   );

   cdb_arbiter arbiter_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .alu_valid (alu_res_valid),
      .alu_res   (alu_res),
      .alu_ready (alu_res_ready),
      .mem_valid (mem_res_valid),
      .mem_res   (mem_res),
      .mem_ready (mem_res_ready),
      .cdb_valid (cdb_valid),
      .cdb       (cdb)
   );

endmodule

//--- verilog/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter import fcpu_pkg::*; (
   input  logic clk,
   input  logic arst_n,
   input  logic alu_valid,
   input  cdb_t alu_res,
   output logic alu_ready,
   input  logic mem_valid,
   input  cdb_t mem_res,
   output logic mem_ready,
   output logic cdb_valid,
   output cdb_t cdb
);

   logic any_valid;
   cdb_t winner;

   // Memory results have priority and the ALU waits a cycle on a collision
   assign mem_ready = mem_valid;
   assign alu_ready = alu_valid && !mem_valid;
   assign any_valid = mem_valid || alu_valid;
   assign winner    = mem_valid ? mem_res : alu_res;

   // The bus is never back-pressured, so the register reloads every cycle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         cdb_valid <= 1'b0;
      else
         cdb_valid <= any_valid;
   end

   always_ff @(posedge clk) begin
      if (any_valid)
         cdb <= winner;
   end

endmodule

//--- verilog/memory_management_unit.sv
`timescale 1ns/1ps

module memory_management_unit import fcpu_pkg::*; (
   input  logic   clk,
   input  logic   arst_n,
   input  logic   valid,
   input  issue_t entry,
   output logic   pop,
   output logic   res_valid,
   output cdb_t   res,
   input  logic   res_ready
);

   localparam int MEM_WORDS = 16;
   localparam int ADDR_W    = $clog2(MEM_WORDS);

   data_t             mem [MEM_WORDS];
   issue_t            s1;
   logic              s1_valid;
   logic              s1_adv;
   data_t             eff_addr;
   logic [ADDR_W-1:0] addr;
   logic              is_store;

   // Stage 1 moves on only if stage 2 is free or being taken
   assign s1_adv = s1_valid && (!res_valid || res_ready);
   assign pop    = valid && (!s1_valid || s1_adv);

   assign eff_addr = s1.op_a + s1.imm;
   assign addr     = eff_addr[ADDR_W-1:0];
   assign is_store = (s1.opcode == OP_ST);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         s1_valid  <= 1'b0;
         res_valid <= 1'b0;
         for (int i = 0; i < MEM_WORDS; i++)
            mem[i] <= '0;
      end else begin
         if (pop)
            s1_valid <= 1'b1;
         else if (s1_adv)
            s1_valid <= 1'b0;

         if (s1_adv)
            res_valid <= 1'b1;
         else if (res_ready)
            res_valid <= 1'b0;

         if (s1_adv && is_store)
            mem[addr] <= s1.op_b;
      end
   end

   always_ff @(posedge clk) begin
      if (pop)
         s1 <= entry;
      if (s1_adv) begin
         res.tag      <= s1.tag;
         res.rd       <= s1.rd;
         res.write_en <= s1.write_en;
         // A store reports the value it wrote
         res.value    <= is_store ? s1.op_b : mem[addr];
      end
   end

endmodule

//--- verilog/alu_unit.sv
`timescale 1ns/1ps

module alu_unit import fcpu_pkg::*; (
   input  logic   clk,
   input  logic   arst_n,
   input  logic   valid,
   input  issue_t entry,
   output logic   pop,
   output logic   res_valid,
   output cdb_t   res,
   input  logic   res_ready
);

   data_t result;

   // Take a new operation when the result register is empty or draining
   assign pop = valid && (!res_valid || res_ready);

   always_comb begin
      case (entry.opcode)
         OP_ADD:  result = entry.op_a + entry.op_b;
         OP_SUB:  result = entry.op_a - entry.op_b;
         OP_AND:  result = entry.op_a & entry.op_b;
         OP_XOR:  result = entry.op_a ^ entry.op_b;
         OP_ADDI: result = entry.op_a + entry.imm;
         OP_LI:   result = entry.imm;
         default: result = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         res_valid <= 1'b0;
      end else begin
         if (pop)
            res_valid <= 1'b1;
         else if (res_ready)
            res_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         res.tag      <= entry.tag;
         res.rd       <= entry.rd;
         res.write_en <= entry.write_en;
         res.value    <= result;
      end
   end

endmodule

//--- verilog/fcpu_decode.sv
`timescale 1ns/1ps
`include "fcpu_macros.svh"

module fcpu_decode import fcpu_pkg::*; (
   input  logic   clk,
   input  logic   arst_n,
   input  logic   instr_valid,
   input  instr_t instr,
   output logic   instr_credit,
   output logic   alu_push,
   output issue_t alu_entry,
   input  logic   alu_credit,
   output logic   mem_push,
   output issue_t mem_entry,
   input  logic   mem_credit,
   input  logic   cdb_valid,
   input  cdb_t   cdb
);

   localparam int QCNT_W = $clog2(`FCPU_QDEPTH + 1);

   data_t                 regs [`FCPU_NREGS];
   logic [`FCPU_NREGS-1:0] busy;
   tag_t                  tag;
   logic [QCNT_W-1:0]     alu_cnt;
   logic [QCNT_W-1:0]     mem_cnt;

   logic     head_valid;
   instr_t   head;
   reg_idx_t rs2;
   logic     to_mem;
   logic     write_en;
   logic     srcs_ready;
   logic     have_credit;
   logic     issue;
   issue_t   entry;

   // Skid buffer for incoming instructions that returns a credit on each pop
   issue_queue #(
      .entry_t (instr_t),
      .depth   (`FCPU_INSTR_CREDITS)
   ) instr_buf_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .push      (instr_valid),
      .entry_in  (instr),
      .valid     (head_valid),
      .entry_out (head),
      .pop       (issue),
      .credit    (instr_credit)
   );

   assign rs2 = head.imm[REG_W-1:0];

   always_comb begin
      to_mem   = (head.opcode == OP_LD) || (head.opcode == OP_ST);
      write_en = (head.opcode != OP_ST);

      // rd is a source for ST and a WAW guard for everything else
      srcs_ready = !busy[head.rd];
      if (head.opcode != OP_LI)
         srcs_ready = srcs_ready && !busy[head.rs1];
      if (head.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_XOR})
         srcs_ready = srcs_ready && !busy[rs2];

      have_credit = to_mem ? (mem_cnt != '0) : (alu_cnt != '0);
      issue       = head_valid && srcs_ready && have_credit;

      entry.tag      = tag;
      entry.opcode   = head.opcode;
      entry.rd       = head.rd;
      entry.write_en = write_en;
      entry.op_a     = regs[head.rs1];
      entry.op_b     = (head.opcode == OP_ST) ? regs[head.rd] : regs[rs2];
      if (head.opcode == OP_LI)
         entry.imm = {{(`FCPU_DATA_W - 9){1'b0}}, head.rs1, head.imm};
      else
         entry.imm = {{(`FCPU_DATA_W - 6){head.imm[5]}}, head.imm};
   end

   assign alu_push  = issue && !to_mem;
   assign mem_push  = issue && to_mem;
   assign alu_entry = entry;
   assign mem_entry = entry;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `FCPU_NREGS; i++)
            regs[i] <= '0;
         busy    <= '0;
         tag     <= '0;
         alu_cnt <= QCNT_W'(`FCPU_QDEPTH);
         mem_cnt <= QCNT_W'(`FCPU_QDEPTH);
      end else begin
         if (cdb_valid && cdb.write_en) begin
            regs[cdb.rd] <= cdb.value;
            busy[cdb.rd] <= 1'b0;
         end
         if (issue && write_en)
            busy[head.rd] <= 1'b1;
         if (issue)
            tag <= tag + 1'b1;
         alu_cnt <= alu_cnt + QCNT_W'(alu_credit) - QCNT_W'(alu_push);
         mem_cnt <= mem_cnt + QCNT_W'(mem_credit) - QCNT_W'(mem_push);
      end
   end

endmodule

//--- verilog/issue_queue.sv
`timescale 1ns/1ps
`include "fcpu_macros.svh"

module issue_queue import fcpu_pkg::*; #(
   parameter type entry_t = issue_t,
   parameter int  depth   = `FCPU_QDEPTH
) (
   input  logic   clk,
   input  logic   arst_n,
   input  logic   push,
   input  entry_t entry_in,
   output logic   valid,
   output entry_t entry_out,
   input  logic   pop,
   output logic   credit
);

   localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
   localparam int CNT_W = $clog2(depth + 1);

   entry_t           slots [depth];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(depth - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   assign valid     = (count != '0);
   assign entry_out = slots[rd_ptr];
   assign do_pop    = pop & valid;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         credit <= 1'b0;
      end else begin
         if (push)
            wr_ptr <= next_ptr(wr_ptr);
         if (do_pop)
            rd_ptr <= next_ptr(rd_ptr);
         count  <= count + CNT_W'(push) - CNT_W'(do_pop);
         // One credit back to the sender per entry removed
         credit <= do_pop;
      end
   end

   always_ff @(posedge clk) begin
      if (push)
         slots[wr_ptr] <= entry_in;
   end

endmodule

//--- verilog/fcpu_pkg.sv
`include "fcpu_macros.svh"

package fcpu_pkg;

   localparam int REG_W = $clog2(`FCPU_NREGS);

   typedef logic [`FCPU_DATA_W-1:0] data_t;
   typedef logic [`FCPU_TAG_W-1:0]  tag_t;
   typedef logic [REG_W-1:0]        reg_idx_t;

   typedef enum logic [3:0] {
      OP_ADD  = 4'h0,
      OP_SUB  = 4'h1,
      OP_AND  = 4'h2,
      OP_XOR  = 4'h3,
      OP_ADDI = 4'h4,
      OP_LI   = 4'h5,
      OP_LD   = 4'h6,
      OP_ST   = 4'h7
   } opcode_t;

   // Instruction word as it arrives from the source
   // rs2 sits in imm[2:0] for register-register operations
   typedef struct packed {
      opcode_t    opcode;
      reg_idx_t   rd;
      reg_idx_t   rs1;
      logic [5:0] imm;
   } instr_t;

   // Operation with its operands already read, as held in the issue queues
   typedef struct packed {
      tag_t     tag;
      opcode_t  opcode;
      reg_idx_t rd;
      logic     write_en;
      data_t    op_a;
      data_t    op_b;
      data_t    imm;
   } issue_t;

   // One result on the common data bus
   typedef struct packed {
      tag_t     tag;
      reg_idx_t rd;
      logic     write_en;
      data_t    value;
   } cdb_t;

endpackage

//--- verilog/fcpu_macros.svh
`ifndef FCPU_MACROS_SVH
`define FCPU_MACROS_SVH

// Register and data path width
`define FCPU_DATA_W 16

// Architectural registers, indexed by 3-bit fields in the instruction word
`define FCPU_NREGS 8

// Entries per issue queue and starting credits held by decode
`define FCPU_QDEPTH 2

// Credits the instruction source starts with
`define FCPU_INSTR_CREDITS 2

// Result tag width
`define FCPU_TAG_W 4

`endif
